/* design/epochtv1.sv */
/*
 * Epoch TV-1 video chip, background and CPU bus
 * Top level connecting timing, registers, bus, renderer and color
 */
`timescale 1ns/1ps
`include "tv1_settings.svh"

module epochtv1 (
  input  logic                              CLK,
  input  logic                              cpu_wait_cnt_resetting,
  input  logic                              CE,
  input  logic                              CP1_POSEDGE,
  input  logic [12:0]                       A,
  input  logic [7:0]                        DB_I,
  output logic [7:0]                        DB_O,
  output logic                              DB_OE,
  input  logic                              RDB,
  input  logic                              WRB,
  input  logic                              CSB,
  output logic                              WAITB,
  output logic                              SCPUB,
  input  logic [$clog2(`TV1_CHR_BYTES)-1:0] ROMINIT_ADDR,
  input  logic [7:0]                        ROMINIT_DATA,
  input  logic                              ROMINIT_VALID,
  output logic                              VBL,
  output logic                              DE,
  output logic                              HS,
  output logic                              VS,
  output tv1_pkg::rgb_t                     RGB
);
  import tv1_pkg::*;

  video_pos_t                        row;
  video_pos_t                        col;
  logic                              render_px;
  logic                              vsync_start;
  logic                              reg_wr;
  logic [1:0]                        reg_sel;
  logic [$clog2(`TV1_BGM_WORDS)-1:0] bgm_cpu_addr;
  logic [3:0]                        bgm_cpu_we;
  logic [31:0]                       bgm_cpu_wdata;
  logic [31:0]                       bgm_cpu_rdata;
  logic                              bm_ena;
  logic                              bm_lores;
  logic                              bm_invx;
  logic                              bm_invy;
  pixel_color_t                      bm_clr_bg;
  pixel_color_t                      bm_clr_fg;
  pixel_color_t                      ch_clr_bg;
  pixel_color_t                      ch_clr_fg;
  logic [3:0]                        bm_xmax;
  logic [3:0]                        bm_ymax;
  pixel_color_t                      bg_px;

  // All internal nets share the port names of the blocks
  tv1_video_timing i_video_timing (.*);
  tv1_ctrl_regs i_ctrl_regs (.*);
  tv1_cpu_bus i_cpu_bus (.*);
  tv1_bg_render i_bg_render (.*);
  tv1_color_gen i_color_gen (.*);

endmodule

/* design/tv1_bg_render.sv */
/*
 * Epoch TV-1 background renderer
 * BGM, character ROM and the character / bitmap pixel pipeline
 */
`timescale 1ns/1ps
`include "tv1_settings.svh"

module tv1_bg_render (
  input  logic                              CLK,
  input  logic                              CE,
  input  tv1_pkg::video_pos_t               row,
  input  tv1_pkg::video_pos_t               col,
  input  logic                              bm_ena,
  input  logic                              bm_lores,
  input  logic                              bm_invx,
  input  logic                              bm_invy,
  input  tv1_pkg::pixel_color_t             bm_clr_bg,
  input  tv1_pkg::pixel_color_t             bm_clr_fg,
  input  tv1_pkg::pixel_color_t             ch_clr_bg,
  input  tv1_pkg::pixel_color_t             ch_clr_fg,
  input  logic [3:0]                        bm_xmax,
  input  logic [3:0]                        bm_ymax,
  input  logic [$clog2(`TV1_BGM_WORDS)-1:0] bgm_cpu_addr,
  input  logic [3:0]                        bgm_cpu_we,
  input  logic [31:0]                       bgm_cpu_wdata,
  output logic [31:0]                       bgm_cpu_rdata,
  input  logic [$clog2(`TV1_CHR_BYTES)-1:0] ROMINIT_ADDR,
  input  logic [7:0]                        ROMINIT_DATA,
  input  logic                              ROMINIT_VALID,
  output tv1_pkg::pixel_color_t             bg_px
);
  import tv1_pkg::*;

  localparam int BGM_AW = $clog2(`TV1_BGM_WORDS);
  localparam int CHR_AW = $clog2(`TV1_CHR_BYTES);

  logic [31:0]       bgm [`TV1_BGM_WORDS];
  logic [7:0]        chr [`TV1_CHR_BYTES];
  logic [31:0]       bgm_rd;
  logic [7:0]        chr_rd;
  logic [BGM_AW-1:0] bgr_addr;
  logic [CHR_AW-1:0] chr_addr;
  logic [4:0]        tx;
  logic [4:0]        ty;
  logic              tile_load;
  logic              is_ch;
  logic              is_bm;
  logic [7:0]        tile_byte;
  logic [2:0]        hi_sel;
  logic [2:0]        lo_sel;
  logic [1:0]        hi_bits;
  logic [3:0]        lo_bits;
  logic [7:0]        ch_pat;
  logic [7:0]        bm_pat;
  logic [7:0]        pat_rev;
  logic [7:0]        shift_q;
  pixel_color_t      bm_fgc;
  pixel_color_t      bgc_q;
  pixel_color_t      fgc_q;

  ////////////////////
  // BGM, separate CPU and renderer ports
  always_ff @(posedge CLK) begin
    bgm_cpu_rdata <= bgm[bgm_cpu_addr];
    for (int i = 0; i < 4; i++) begin
      if (bgm_cpu_we[i])
        bgm[bgm_cpu_addr][i*8 +: 8] <= bgm_cpu_wdata[i*8 +: 8];
    end
  end

  always_ff @(posedge CLK) begin
    bgm_rd <= bgm[bgr_addr];
  end

  // Character pattern ROM
  always_ff @(posedge CLK) begin
    if (ROMINIT_VALID)
      chr[ROMINIT_ADDR] <= ROMINIT_DATA;
    chr_rd <= chr[chr_addr];
  end

  ////////////////////
  // Tile fetch
  assign tx = col[7:3];
  assign ty = row[7:3];
  assign tile_load = (col[2:0] == 3'd4);
  assign is_ch = ((tx[4:1] < bm_xmax) ^ bm_invx) && ((ty[4:1] < bm_ymax) ^ bm_invy);
  assign is_bm = bm_ena && !is_ch;

  assign bgr_addr = {ty[4:1], tx[4:2]};
  assign tile_byte = bgm_rd[tx[1:0]*8 +: 8];
  assign chr_addr = {tile_byte[6:0], row[2:0]};
  // Odd tile rows are blank, 6 pixels used per glyph line
  assign ch_pat = ty[0] ? 8'h00 : {2'b00, chr_rd[7:2]};

  // Bitmap field select by pixel row
  assign hi_sel = {~row[3:2], 1'b0};
  assign lo_sel = {~row[3], 2'b00};
  assign hi_bits = tile_byte[hi_sel +: 2];
  assign lo_bits = tile_byte[lo_sel +: 4];

  always_comb begin
    bm_fgc = bm_clr_fg;
    bm_pat = '0;
    if (is_bm) begin
      if (bm_lores) begin
        // Nibble 0 lets the background color through
        if (lo_bits != 4'd0) begin
          bm_pat = '1;
          bm_fgc = lo_bits;
        end
      end else
        bm_pat = {{4{hi_bits[1]}}, {4{hi_bits[0]}}};
    end
    for (int i = 0; i < 8; i++)
      pat_rev[7 - i] = is_ch ? ch_pat[i] : bm_pat[i];
  end

  // Pattern shifter, LSB out first
  always_ff @(posedge CLK) begin
    if (CE) begin
      if (tile_load) begin
        bgc_q <= is_ch ? ch_clr_bg : bm_clr_bg;
        fgc_q <= is_ch ? ch_clr_fg : bm_fgc;
        shift_q <= pat_rev;
      end else
        shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  assign bg_px = shift_q[0] ? fgc_q : bgc_q;

endmodule

/* design/tv1_color_gen.sv */
/*
 * Epoch TV-1 color generator
 * Black border outside the render window, fixed RGB palette
 */
`timescale 1ns/1ps

module tv1_color_gen (
  input  logic                  CLK,
  input  logic                  CE,
  input  logic                  render_px,
  input  tv1_pkg::pixel_color_t bg_px,
  output tv1_pkg::rgb_t         RGB
);
  import tv1_pkg::*;

  logic         visible_q;
  pixel_color_t pd;

  always_ff @(posedge CLK) begin
    if (CE)
      visible_q <= render_px;
  end

  // Index 1 is black
  assign pd = visible_q ? bg_px : 4'd1;

  // Levels fall off as R+G+B grows, as on the RGB connector
  always_comb begin
    case (pd)
      4'd0:  RGB = {8'd0,   8'd0,   8'd160};
      4'd1:  RGB = {8'd0,   8'd0,   8'd0};
      4'd2:  RGB = {8'd0,   8'd0,   8'd245};
      4'd3:  RGB = {8'd160, 8'd0,   8'd235};
      4'd4:  RGB = {8'd0,   8'd245, 8'd0};
      4'd5:  RGB = {8'd150, 8'd235, 8'd150};
      4'd6:  RGB = {8'd0,   8'd235, 8'd235};
      4'd7:  RGB = {8'd0,   8'd160, 8'd0};
      4'd8:  RGB = {8'd245, 8'd0,   8'd0};
      4'd9:  RGB = {8'd235, 8'd160, 8'd0};
      4'd10: RGB = {8'd235, 8'd0,   8'd235};
      4'd11: RGB = {8'd235, 8'd150, 8'd150};
      4'd12: RGB = {8'd235, 8'd235, 8'd0};
      4'd13: RGB = {8'd160, 8'd160, 8'd0};
      4'd14: RGB = {8'd150, 8'd150, 8'd150};
      default: RGB = {8'd225, 8'd225, 8'd225};
    endcase
  end

endmodule

/* design/tv1_cpu_bus.sv */
/*
 * Epoch TV-1 CPU bus interface
 * Address decode, WAITB wait-state generator and read-back latch
 */
`timescale 1ns/1ps
`include "tv1_settings.svh"

module tv1_cpu_bus (
  input  logic                              CLK,
  input  logic                              cpu_wait_cnt_resetting,
  input  logic                              CE,
  input  logic                              CP1_POSEDGE,
  input  logic [12:0]                       A,
  input  logic [7:0]                        DB_I,
  output logic [7:0]                        DB_O,
  output logic                              DB_OE,
  input  logic                              RDB,
  input  logic                              WRB,
  input  logic                              CSB,
  output logic                              WAITB,
  output logic                              SCPUB,
  output logic                              reg_wr,
  output logic [1:0]                        reg_sel,
  output logic [$clog2(`TV1_BGM_WORDS)-1:0] bgm_cpu_addr,
  output logic [3:0]                        bgm_cpu_we,
  output logic [31:0]                       bgm_cpu_wdata,
  input  logic [31:0]                       bgm_cpu_rdata
);
  import tv1_pkg::*;

  cpu_region_t region;
  logic        cpu_rd;
  logic        cpu_wr;
  logic [7:0]  rd_latch;
  logic [2:0]  wait_cnt;
  logic [2:0]  wait_cnt_next;
  logic        waitb_q;
  logic        waitb_next;
  logic        rdb_d;
  logic        rdb_rise;
  logic        wait_expiring;

  always_comb begin
    if (CSB)
      region = REGION_NONE;
    else if (!A[12])
      region = REGION_VRAM;
    else begin
      case (A[11:9])
        3'b000: region = REGION_BGM;
        3'b001: region = REGION_OAM;
        3'b010: region = REGION_REG;
        3'b011: region = REGION_APU;
        default: region = REGION_NONE;
      endcase
    end
  end

  assign cpu_rd = !(CSB || RDB);
  assign cpu_wr = !(CSB || WRB);

  ////////////////////
  // Wait states
  always_comb begin
    wait_cnt_next = wait_cnt;
    if (wait_cnt != '0)
      wait_cnt_next = wait_cnt - 3'd1;
    else if (!waitb_q) begin
      if (cpu_rd)
        wait_cnt_next = (region == REGION_BGM) ? `TV1_WAIT_RD_BGM - 3'd1
                                               : `TV1_WAIT_RD - 3'd1;
      // Early RDB release stretches the following write
      if (rdb_rise)
        wait_cnt_next = `TV1_WAIT_WR;
    end
  end

  assign wait_expiring = (wait_cnt != '0) && (wait_cnt_next == '0);
  assign rdb_rise = RDB && !rdb_d;

  always_comb begin
    waitb_next = waitb_q;
    if (wait_expiring)
      waitb_next = !waitb_q;
    else if (!waitb_q && (cpu_wr || rdb_rise))
      waitb_next = 1'b1;
    else if (waitb_q && !(cpu_rd || cpu_wr))
      waitb_next = 1'b0;
  end

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      wait_cnt <= '0;
      waitb_q <= 1'b0;
      rdb_d <= 1'b1;
    end else if (CP1_POSEDGE) begin
      wait_cnt <= wait_cnt_next;
      waitb_q <= waitb_next;
      rdb_d <= RDB;
    end
  end

  // Read data, FF outside BGM
  always_ff @(posedge CLK) begin
    if (CE && cpu_rd)
      rd_latch <= (region == REGION_BGM) ? bgm_cpu_rdata[A[1:0]*8 +: 8] : 8'hFF;
  end

  assign DB_O = rd_latch;
  assign DB_OE = cpu_rd;
  assign WAITB = CSB || waitb_q;
  assign SCPUB = (region != REGION_APU);
  assign reg_wr = (region == REGION_REG) && cpu_wr;
  assign reg_sel = A[1:0];
  assign bgm_cpu_addr = A[8:2];
  assign bgm_cpu_we = {4{(region == REGION_BGM) && cpu_wr}} & (4'b0001 << A[1:0]);
  assign bgm_cpu_wdata = {4{DB_I}};

  wait_cnt_bounded: assert property (@(posedge CLK) disable iff (cpu_wait_cnt_resetting)
    wait_cnt <= `TV1_WAIT_RD_BGM);
  no_drive_unselected: assert property (@(posedge CLK) CSB |-> !DB_OE);

endmodule

/* design/tv1_ctrl_regs.sv */
/*
 * Epoch TV-1 control registers ($1400-$1403)
 * CPU writes go to shadow copies, moved to the active set at vsync
 */
`timescale 1ns/1ps

module tv1_ctrl_regs (
  input  logic                  CLK,
  input  logic                  cpu_wait_cnt_resetting,
  input  logic                  CE,
  input  logic                  vsync_start,
  input  logic                  reg_wr,
  input  logic [1:0]            reg_sel,
  input  logic [7:0]            DB_I,
  output logic                  bm_ena,
  output logic                  bm_lores,
  output logic                  bm_invx,
  output logic                  bm_invy,
  output tv1_pkg::pixel_color_t bm_clr_bg,
  output tv1_pkg::pixel_color_t bm_clr_fg,
  output tv1_pkg::pixel_color_t ch_clr_bg,
  output tv1_pkg::pixel_color_t ch_clr_fg,
  output logic [3:0]            bm_xmax,
  output logic [3:0]            bm_ymax
);

  logic [7:0] shadow_q [4];
  logic [7:0] active_q [4];

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      for (int i = 0; i < 4; i++) begin
        shadow_q[i] <= '0;
        active_q[i] <= '0;
      end
    end else begin
      if (reg_wr)
        shadow_q[reg_sel] <= DB_I;
      // New settings apply from the next frame
      if (CE && vsync_start)
        active_q <= shadow_q;
    end
  end

  // Reg 0 bits 2-5 are sprite controls, kept but unused
  assign bm_ena = active_q[0][0];
  assign bm_lores = active_q[0][1];
  assign bm_invx = active_q[0][6];
  assign bm_invy = active_q[0][7];
  assign bm_clr_bg = active_q[1][3:0];
  assign bm_clr_fg = active_q[1][7:4];
  // Character / bitmap window split
  assign bm_xmax = active_q[2][3:0];
  assign bm_ymax = active_q[2][7:4];
  assign ch_clr_bg = active_q[3][3:0];
  assign ch_clr_fg = active_q[3][7:4];

endmodule

/* design/tv1_pkg.sv */
/*
 * Epoch TV-1 shared types
 * Video position, palette index, output color and CPU address region
 */
package tv1_pkg;

  typedef logic [8:0] video_pos_t;
  typedef logic [3:0] pixel_color_t;
  typedef logic [23:0] rgb_t;

  // CPU address map, $0000-$17FF
  typedef enum logic [2:0] {
    REGION_VRAM,
    REGION_BGM,
    REGION_OAM,
    REGION_REG,
    REGION_APU,
    REGION_NONE
  } cpu_region_t;

endpackage

/* design/tv1_settings.svh */
/*
 * Epoch TV-1 build constants
 * Frame geometry, render window, memory sizes and CPU wait lengths
 */
`ifndef TV1_SETTINGS_SVH
`define TV1_SETTINGS_SVH

// Frame size in pixel clocks
`define TV1_NUM_COLS 9'd260
`define TV1_NUM_ROWS 9'd263

// Render window, 208 x 232
`define TV1_FIRST_ROW_RENDER 9'd16
`define TV1_LAST_ROW_RENDER 9'd247
`define TV1_FIRST_COL_RENDER 9'd23
`define TV1_LAST_COL_RENDER 9'd230

// Sync ranges
`define TV1_FIRST_ROW_VSYNC 9'd257
`define TV1_LAST_ROW_VSYNC 9'd259
`define TV1_FIRST_COL_HSYNC 9'd240
`define TV1_LAST_COL_HSYNC 9'd259

// Memory sizes
`define TV1_BGM_WORDS 128
`define TV1_CHR_BYTES 1024

// WAITB low time in CP1 cycles
`define TV1_WAIT_RD_BGM 3'd3
`define TV1_WAIT_RD 3'd2
`define TV1_WAIT_WR 3'd1

`endif

/* design/tv1_video_timing.sv */
/*
 * Epoch TV-1 video timing
 * Free-running row and column counter with render window and sync
 */
`timescale 1ns/1ps
`include "tv1_settings.svh"

module tv1_video_timing (
  input  logic                CLK,
  input  logic                cpu_wait_cnt_resetting,
  input  logic                CE,
  output tv1_pkg::video_pos_t row,
  output tv1_pkg::video_pos_t col,
  output logic                render_px,
  output logic                vsync_start,
  output logic                HS,
  output logic                VS,
  output logic                DE,
  output logic                VBL
);
  import tv1_pkg::*;

  video_pos_t row_next;
  video_pos_t col_next;
  logic       render_row;
  logic       render_col;

  // Wrap at end of line and end of frame
  always_comb begin
    row_next = row;
    col_next = col + 9'd1;
    if (col == `TV1_NUM_COLS - 9'd1) begin
      col_next = '0;
      if (row == `TV1_NUM_ROWS - 9'd1)
        row_next = '0;
      else
        row_next = row + 9'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      row <= '0;
      col <= '0;
    end else if (CE) begin
      row <= row_next;
      col <= col_next;
    end
  end

  assign render_row = (row >= `TV1_FIRST_ROW_RENDER) && (row <= `TV1_LAST_ROW_RENDER);
  assign render_col = (col >= `TV1_FIRST_COL_RENDER) && (col <= `TV1_LAST_COL_RENDER);
  assign render_px = render_row && render_col;
  assign vsync_start = (row == `TV1_FIRST_ROW_VSYNC) && (col == '0);

  ////////////////////
  // Sync outputs, one pixel behind the counter
  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      HS <= 1'b0;
      VS <= 1'b0;
      DE <= 1'b0;
      VBL <= 1'b0;
    end else if (CE) begin
      HS <= (col >= `TV1_FIRST_COL_HSYNC) && (col <= `TV1_LAST_COL_HSYNC);
      VS <= (row >= `TV1_FIRST_ROW_VSYNC) && (row <= `TV1_LAST_ROW_VSYNC);
      DE <= render_px;
      VBL <= !render_row;
    end
  end

  col_in_range: assert property (@(posedge CLK) disable iff (cpu_wait_cnt_resetting)
    col < `TV1_NUM_COLS);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the epochtv1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_epochtv1 -f sources.f \
  -Mdir obj_dir -o tb_epochtv1_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_epochtv1_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TB PASSED" "$log"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

/* sources.f */
+incdir+design
design/tv1_pkg.sv
design/tv1_video_timing.sv
design/tv1_ctrl_regs.sv
design/tv1_cpu_bus.sv
design/tv1_bg_render.sv
design/tv1_color_gen.sv
design/epochtv1.sv
testbench/tb_clock_gen.sv
testbench/tb_epochtv1.sv

/* testbench/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 4 ns clock, reset held for 5 cycles and released on a falling edge
 */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic cpu_wait_cnt_resetting
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    cpu_wait_cnt_resetting = 1'b1;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    cpu_wait_cnt_resetting = 1'b0;
  end

endmodule

/* testbench/tb_epochtv1.sv */
/*
 * Epoch TV-1 testbench
 * Frame timing, BGM access, wait states, delayed register update and
 * low-resolution bitmap fill against a byte model of BGM
 */
`timescale 1ns/1ps
`include "tv1_settings.svh"

module tb_epochtv1;

  localparam int FRAME_CYCLES = int'(`TV1_NUM_COLS) * int'(`TV1_NUM_ROWS);
  localparam int RENDER_ROWS =
    int'(`TV1_LAST_ROW_RENDER) - int'(`TV1_FIRST_ROW_RENDER) + 1;
  localparam int RENDER_PIXELS =
    (int'(`TV1_LAST_COL_RENDER) - int'(`TV1_FIRST_COL_RENDER) + 1) * RENDER_ROWS;
  localparam int VBLANK_CYCLES =
    (int'(`TV1_NUM_ROWS) - RENDER_ROWS) * int'(`TV1_NUM_COLS);
  localparam int VSYNC_CYCLES =
    (int'(`TV1_LAST_ROW_VSYNC) - int'(`TV1_FIRST_ROW_VSYNC) + 1) * int'(`TV1_NUM_COLS);
  localparam int BGM_BYTES = `TV1_BGM_WORDS * 4;
  localparam int RANDOM_WRITES = 40;
  // Longest access is drive, three wait cycles and release
  localparam int ACCESS_CYCLES = 6;
  localparam int BUS_ACCESSES = 2 * BGM_BYTES + 2 * RANDOM_WRITES + 16;
  // One timing frame and up to three frames per render test plus a spare
  localparam int TIMEOUT_CYCLES =
    8 * FRAME_CYCLES + `TV1_CHR_BYTES + BUS_ACCESSES * ACCESS_CYCLES;

  logic        CLK;
  logic        cpu_wait_cnt_resetting;
  logic        CE;
  logic        CP1_POSEDGE;
  logic [12:0] A;
  logic [7:0]  DB_I;
  logic [7:0]  DB_O;
  logic        DB_OE;
  logic        RDB;
  logic        WRB;
  logic        CSB;
  logic        WAITB;
  logic        SCPUB;
  logic [$clog2(`TV1_CHR_BYTES)-1:0] ROMINIT_ADDR;
  logic [7:0]  ROMINIT_DATA;
  logic        ROMINIT_VALID;
  logic        VBL;
  logic        DE;
  logic        HS;
  logic        VS;
  logic [23:0] RGB;

  // Fixed RGB palette with black at index 1
  logic [23:0] palette [16] = '{
    24'h0000A0, 24'h000000, 24'h0000F5, 24'hA000EB,
    24'h00F500, 24'h96EB96, 24'h00EBEB, 24'h00A000,
    24'hF50000, 24'hEBA000, 24'hEB00EB, 24'hEB9696,
    24'hEBEB00, 24'hA0A000, 24'h969696, 24'hE1E1E1
  };

  logic [7:0] bgm_model [BGM_BYTES];
  logic [7:0] reg_model [4];
  logic [8:0] wr_addr [RANDOM_WRITES];
  int         seed = 10;
  int         errors = 0;
  int         checks = 0;
  int         cycle_cnt = 0;

  tb_clock_gen i_clock_gen (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting)
  );

  epochtv1 i_epochtv1 (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .CE                     (CE),
    .CP1_POSEDGE            (CP1_POSEDGE),
    .A                      (A),
    .DB_I                   (DB_I),
    .DB_O                   (DB_O),
    .DB_OE                  (DB_OE),
    .RDB                    (RDB),
    .WRB                    (WRB),
    .CSB                    (CSB),
    .WAITB                  (WAITB),
    .SCPUB                  (SCPUB),
    .ROMINIT_ADDR           (ROMINIT_ADDR),
    .ROMINIT_DATA           (ROMINIT_DATA),
    .ROMINIT_VALID          (ROMINIT_VALID),
    .VBL                    (VBL),
    .DE                     (DE),
    .HS                     (HS),
    .VS                     (VS),
    .RGB                    (RGB)
  );

  ////////////////////
  // Helpers

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("ERR %s: expected %0h, actual %0h", name, exp, act);
  endtask

  // Initial BGM contents that depend on every address bit
  function automatic logic [7:0] fill_byte(input logic [8:0] a);
    return {a[0], a[7:1]} ^ {8{a[8]}};
  endfunction

  // One CPU access from one falling edge to another
  task automatic bus_access(input logic wr, input logic [12:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata,
                            output int waits);
    logic exp_scpub;
    A = addr;
    DB_I = wdata;
    CSB = 1'b0;
    if (wr)
      WRB = 1'b0;
    else
      RDB = 1'b0;
    // WAITB drops in the cycle the access starts
    waits = 1;
    @(negedge CLK);
    while (!WAITB) begin
      waits++;
      @(negedge CLK);
    end
    rdata = DB_O;
    if (!wr) begin
      checks++;
      if (DB_OE !== 1'b1) begin
        errors++;
        $display("DB_OE was not driven during the read of address %h", addr);
      end
    end
    // Sound CPU select goes low only for $1600-$17FF
    exp_scpub = (addr[12:9] != 4'b1011);
    checks++;
    if (SCPUB !== exp_scpub)
      report_mismatch("scpub", 32'(exp_scpub), 32'(SCPUB));
    CSB = 1'b1;
    WRB = 1'b1;
    RDB = 1'b1;
    @(negedge CLK);
  endtask

  task automatic cpu_write(input logic [12:0] addr, input logic [7:0] data,
                           output int waits);
    logic [7:0] ignored;
    bus_access(1'b1, addr, data, ignored, waits);
    if (addr[12:9] == 4'b1000)
      bgm_model[addr[8:0]] = data;
    else if (addr[12:9] == 4'b1010)
      reg_model[addr[1:0]] = data;
  endtask

  task automatic cpu_read(input logic [12:0] addr, output logic [7:0] data,
                          output int waits);
    bus_access(1'b0, addr, 8'h00, data, waits);
  endtask

  task automatic load_char_rom();
    for (int i = 0; i < `TV1_CHR_BYTES; i++) begin
      ROMINIT_ADDR = i[$clog2(`TV1_CHR_BYTES)-1:0];
      ROMINIT_DATA = 8'h00;
      ROMINIT_VALID = 1'b1;
      @(negedge CLK);
    end
    ROMINIT_VALID = 1'b0;
  endtask

  task automatic wait_vs_rise();
    logic prev_vs;
    prev_vs = VS;
    @(negedge CLK);
    while (!(VS && !prev_vs)) begin
      prev_vs = VS;
      @(negedge CLK);
    end
  endtask

  task automatic wait_vs_fall();
    while (!VS)
      @(negedge CLK);
    while (VS)
      @(negedge CLK);
  endtask

  task automatic check_frame_timing();
    int   hs_pulses;
    int   de_cycles;
    int   vs_cycles;
    int   vbl_cycles;
    logic prev_hs;
    hs_pulses = 0;
    de_cycles = 0;
    vs_cycles = 0;
    vbl_cycles = 0;
    prev_hs = HS;
    for (int i = 0; i < FRAME_CYCLES; i++) begin
      @(negedge CLK);
      if (HS && !prev_hs)
        hs_pulses++;
      if (DE)
        de_cycles++;
      if (VS)
        vs_cycles++;
      if (VBL)
        vbl_cycles++;
      prev_hs = HS;
    end
    checks += 4;
    if (hs_pulses != int'(`TV1_NUM_ROWS))
      report_mismatch("frame_hs_pulses", int'(`TV1_NUM_ROWS), hs_pulses);
    if (de_cycles != RENDER_PIXELS)
      report_mismatch("frame_de_cycles", RENDER_PIXELS, de_cycles);
    if (vs_cycles != VSYNC_CYCLES)
      report_mismatch("frame_vs_cycles", VSYNC_CYCLES, vs_cycles);
    if (vbl_cycles != VBLANK_CYCLES)
      report_mismatch("frame_vbl_cycles", VBLANK_CYCLES, vbl_cycles);
  endtask

  // Every rendered pixel up to the next VS shows one color and the border is black
  task automatic scan_frame_colors(input string name, input logic [3:0] idx);
    logic        prev_vs;
    logic [23:0] exp;
    int          bad;
    int          de_seen;
    bad = 0;
    de_seen = 0;
    prev_vs = VS;
    forever begin
      @(negedge CLK);
      exp = DE ? palette[idx] : palette[1];
      if (DE)
        de_seen++;
      checks++;
      if (RGB !== exp) begin
        bad++;
        if (bad <= 4)
          report_mismatch(name, 32'(exp), 32'(RGB));
        else
          errors++;
      end
      if (VS && !prev_vs)
        break;
      prev_vs = VS;
    end
    if (bad > 4)
      $display("%s: %0d more pixel mismatches not listed", name, bad - 4);
    checks++;
    if (de_seen == 0) begin
      errors++;
      $display("%s: no rendered pixels were seen before the next VS", name);
    end
  endtask

  ////////////////////
  // Test sequence

  initial begin
    logic [31:0] r;
    logic [7:0]  rd;
    int          waits;
    logic [3:0]  old_idx;
    logic [3:0]  ch_bg;
    logic [3:0]  nib;

    CE = 1'b1;
    CP1_POSEDGE = 1'b1;
    A = '0;
    DB_I = '0;
    RDB = 1'b1;
    WRB = 1'b1;
    CSB = 1'b1;
    ROMINIT_ADDR = '0;
    ROMINIT_DATA = '0;
    ROMINIT_VALID = 1'b0;
    for (int i = 0; i < 4; i++)
      reg_model[i] = 8'h00;

    @(negedge CLK);
    while (cpu_wait_cnt_resetting)
      @(negedge CLK);

    // Blank glyphs and known BGM contents
    load_char_rom();
    for (int a = 0; a < BGM_BYTES; a++)
      cpu_write({4'b1000, a[8:0]}, fill_byte(a[8:0]), waits);

    // Frame timing
    check_frame_timing();

    // BGM random writes and read-back
    for (int i = 0; i < RANDOM_WRITES; i++) begin
      r = $random(seed);
      wr_addr[i] = r[8:0];
      cpu_write({4'b1000, r[8:0]}, r[23:16], waits);
    end
    for (int i = 0; i < RANDOM_WRITES; i++) begin
      cpu_read({4'b1000, wr_addr[i]}, rd, waits);
      checks++;
      if (rd !== bgm_model[wr_addr[i]])
        report_mismatch("bgm_readback", 32'(bgm_model[wr_addr[i]]), 32'(rd));
    end

    // Wait states per access type
    r = $random(seed);
    cpu_read({4'b1000, r[8:0]}, rd, waits);
    checks += 2;
    if (waits != int'(`TV1_WAIT_RD_BGM))
      report_mismatch("wait_bgm_read", int'(`TV1_WAIT_RD_BGM), waits);
    if (rd !== bgm_model[r[8:0]])
      report_mismatch("wait_bgm_data", 32'(bgm_model[r[8:0]]), 32'(rd));
    cpu_read({4'b1010, 7'd0, r[10:9]}, rd, waits);
    checks += 2;
    if (waits != int'(`TV1_WAIT_RD))
      report_mismatch("wait_reg_read", int'(`TV1_WAIT_RD), waits);
    if (rd !== 8'hFF)
      report_mismatch("reg_read_data", 32'hFF, 32'(rd));
    cpu_read({1'b0, r[23:12]}, rd, waits);
    checks += 2;
    if (waits != int'(`TV1_WAIT_RD))
      report_mismatch("wait_vram_read", int'(`TV1_WAIT_RD), waits);
    if (rd !== 8'hFF)
      report_mismatch("vram_read_data", 32'hFF, 32'(rd));
    cpu_read({4'b1011, r[8:0]}, rd, waits);
    checks += 2;
    if (waits != int'(`TV1_WAIT_RD))
      report_mismatch("wait_apu_read", int'(`TV1_WAIT_RD), waits);
    if (rd !== 8'hFF)
      report_mismatch("apu_read_data", 32'hFF, 32'(rd));
    cpu_write({4'b1000, r[8:0]}, r[31:24], waits);
    checks++;
    if (waits != int'(`TV1_WAIT_WR))
      report_mismatch("wait_write", int'(`TV1_WAIT_WR), waits);

    // Delayed register update, character mode over the whole screen
    // Bitmap off and no character tiles leaves the bitmap background color
    old_idx = reg_model[1][3:0];
    r = $random(seed);
    ch_bg = r[3:0];
    if (ch_bg == old_idx)
      ch_bg = ~old_idx;
    wait_vs_fall();
    // Inverted split with zero bounds makes every tile a character tile
    cpu_write(13'h1400, 8'hC0, waits);
    cpu_write(13'h1402, 8'h00, waits);
    cpu_write(13'h1403, {r[7:4], ch_bg}, waits);
    scan_frame_colors("reg_delay_old", old_idx);
    scan_frame_colors("reg_delay_new", ch_bg);

    // Low-resolution bitmap fill
    r = $random(seed);
    nib = r[3:0];
    if (nib == 4'd0)
      nib = {1'b1, r[6:4]};
    for (int a = 0; a < BGM_BYTES; a++)
      cpu_write({4'b1000, a[8:0]}, {nib, nib}, waits);
    // Bitmap register colors differ from the fill nibble
    cpu_write(13'h1401, {~nib, ~nib}, waits);
    cpu_write(13'h1402, 8'h00, waits);
    cpu_write(13'h1400, 8'h03, waits);
    wait_vs_rise();
    scan_frame_colors("lores_fill", nib);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule
